//--- rackbus_pkg.sv
package rackbus_pkg;

    // full command word width on the rack bus
    localparam int WORD_BITS = 32;

    // field widths
    localparam int RUNCMD_BITS = 2;
    localparam int MODE1TYPE_BITS = 2;
    localparam int MODE1_BITS = 8;
    localparam int TRIG_BITS = 15;

    // run command that carries nothing
    localparam logic [RUNCMD_BITS-1:0] RUNCMD_NOOP = 2'd0;

    // mode1 type codes
    // special type with noop data means the mode1 field is empty
    localparam logic [MODE1TYPE_BITS-1:0] MODE1_SPECIAL = 2'd3;
    localparam logic [MODE1TYPE_BITS-1:0] MODE1_FWU = 2'd2;
    localparam logic [MODE1_BITS-1:0] MODE1_NOOP = 8'h00;

    // frame timing
    localparam int FRAME_PHASES = 8;
    localparam int PHASE_BITS = $clog2(FRAME_PHASES);
    // registered compares, so the strobes land one phase later
    localparam logic [PHASE_BITS-1:0] PRECAPTURE_PHASE = 3'd5;
    localparam logic [PHASE_BITS-1:0] CAPTURE_PHASE = 3'd6;
    // phase loaded by a sync pulse
    localparam logic [PHASE_BITS-1:0] SYNC_PHASE = 3'd1;

    // field view of a command word, top bit first
    typedef struct packed {
        logic                      ignore;
        logic                      pps;
        logic [RUNCMD_BITS-1:0]    runcmd;
        logic [MODE1TYPE_BITS-1:0] mode1type;
        logic [MODE1_BITS-1:0]     mode1data;
        // always zero
        logic [1:0]                reserved;
        logic                      trig_valid;
        logic [TRIG_BITS-1:0]      trig;
    } rackbus_fields_t;

    // raw view on the bus and serializer, field view in the splice
    typedef union packed {
        logic [WORD_BITS-1:0] raw;
        rackbus_fields_t      f;
    } rackbus_word_u;

endpackage

//--- splice_hold_if.sv
`timescale 1ns/1ns

interface splice_hold_if;
    import rackbus_pkg::*;

    // held local mode1 / firmware byte and its type
    logic [MODE1_BITS-1:0]     hold_mode1data;
    logic [MODE1TYPE_BITS-1:0] hold_mode1type;
    // held local run command
    logic [RUNCMD_BITS-1:0]    hold_runcmd;
    // which local source sits in the holding registers
    logic                      holding_mode1;
    logic                      holding_fwu;
    logic                      holding_runcmd;
    // live pps or pps latched since last capture
    logic                      pps_local;

    // upstream field status, fed back for the ready pulses
    logic                      turf_mode1_invalid;
    logic                      turf_runcmd_invalid;
    logic                      turf_trig_valid;

    modport holding (
        output hold_mode1data, hold_mode1type, hold_runcmd,
        output holding_mode1, holding_fwu, holding_runcmd, pps_local,
        input  turf_mode1_invalid, turf_runcmd_invalid, turf_trig_valid
    );

    modport splice (
        input  hold_mode1data, hold_mode1type, hold_runcmd,
        input  holding_mode1, holding_fwu, holding_runcmd, pps_local,
        output turf_mode1_invalid, turf_runcmd_invalid, turf_trig_valid
    );

endinterface

//--- cmd_phase_gen.sv
`timescale 1ns/1ns

module cmd_phase_gen (
    input  logic sysclk_i,
    input  logic rst_i,
    input  logic sync_i,
    output logic precapture_o,
    output logic capture_o
);
    import rackbus_pkg::*;

    logic [PHASE_BITS-1:0] phase_q;
    logic                  precapture_q;
    logic                  capture_q;

    // frame phase counter
    // sync puts the next cycle at phase 1
    // free runs modulo FRAME_PHASES when no sync comes
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            phase_q <= '0;
        end else if (sync_i) begin
            phase_q <= SYNC_PHASE;
        end else if (phase_q == PHASE_BITS'(FRAME_PHASES - 1)) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // strobes are registered compares
    // precapture high during phase 6, capture high during phase 7
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            precapture_q <= 1'b0;
            capture_q <= 1'b0;
        end else begin
            precapture_q <= (phase_q == PRECAPTURE_PHASE);
            capture_q <= (phase_q == CAPTURE_PHASE);
        end
    end

    assign precapture_o = precapture_q;
    assign capture_o = capture_q;

endmodule

//--- tfio_holding.sv
`timescale 1ns/1ns

module tfio_holding (
    input  logic                                    sysclk_i,
    input  logic                                    rst_i,
    input  logic                                    precapture_i,
    input  logic                                    capture_i,
    input  logic                                    mode1_tvalid_i,
    input  logic [rackbus_pkg::MODE1_BITS-1:0]      mode1_tdata_i,
    input  logic [rackbus_pkg::MODE1TYPE_BITS-1:0]  mode1_tuser_i,
    input  logic                                    fw_tvalid_i,
    input  logic [rackbus_pkg::MODE1_BITS-1:0]      fw_tdata_i,
    input  logic                                    runcmd_tvalid_i,
    input  logic [rackbus_pkg::RUNCMD_BITS-1:0]     runcmd_tdata_i,
    input  logic                                    trig_tvalid_i,
    input  logic                                    tfio_pps_i,
    output logic                                    mode1_tready_o,
    output logic                                    fw_tready_o,
    output logic                                    runcmd_tready_o,
    output logic                                    trig_tready_o,
    splice_hold_if.holding                          hold
);
    import rackbus_pkg::*;

    // holding registers, reloaded every precapture
    logic [MODE1_BITS-1:0]     mode1data_q;
    logic [MODE1TYPE_BITS-1:0] mode1type_q;
    logic [RUNCMD_BITS-1:0]    runcmd_q;

    // which source got sampled
    logic holding_mode1_q;
    logic holding_fwu_q;
    logic holding_runcmd_q;

    // pps seen since the last capture
    logic pps_seen_q;

    // ready pulses, one cycle each
    logic mode1_ack_q;
    logic fw_ack_q;
    logic runcmd_ack_q;
    logic trig_ack_q;

    // sample local data one cycle before the word is taken
    // mode1 stream beats firmware, which beats noop
    // an unused firmware byte is simply resampled next frame
    always_ff @(posedge sysclk_i) begin
        if (precapture_i) begin
            if (mode1_tvalid_i) begin
                mode1data_q <= mode1_tdata_i;
                mode1type_q <= mode1_tuser_i;
            end else if (fw_tvalid_i) begin
                mode1data_q <= fw_tdata_i;
                mode1type_q <= MODE1_FWU;
            end else begin
                mode1data_q <= MODE1_NOOP;
                mode1type_q <= MODE1_SPECIAL;
            end

            if (runcmd_tvalid_i) begin
                runcmd_q <= runcmd_tdata_i;
            end else begin
                runcmd_q <= RUNCMD_NOOP;
            end
        end
    end

    // holding flags, pps latch and ready pulses
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            holding_mode1_q <= 1'b0;
            holding_fwu_q <= 1'b0;
            holding_runcmd_q <= 1'b0;
            pps_seen_q <= 1'b0;
            mode1_ack_q <= 1'b0;
            fw_ack_q <= 1'b0;
            runcmd_ack_q <= 1'b0;
            trig_ack_q <= 1'b0;
        end else begin
            if (precapture_i) begin
                holding_mode1_q <= mode1_tvalid_i;
                holding_fwu_q <= fw_tvalid_i && !mode1_tvalid_i;
                holding_runcmd_q <= runcmd_tvalid_i;
            end

            // latch pps until the word carrying it is taken
            if (capture_i) begin
                pps_seen_q <= 1'b0;
            end else if (tfio_pps_i) begin
                pps_seen_q <= 1'b1;
            end

            // ready only when the held data really went into the word
            mode1_ack_q <= capture_i && holding_mode1_q && hold.turf_mode1_invalid;
            fw_ack_q <= capture_i && holding_fwu_q && hold.turf_mode1_invalid;
            runcmd_ack_q <= capture_i && holding_runcmd_q && hold.turf_runcmd_invalid;
            // local trigger only used when upstream has none
            trig_ack_q <= capture_i && trig_tvalid_i && !hold.turf_trig_valid;
        end
    end

    assign hold.hold_mode1data = mode1data_q;
    assign hold.hold_mode1type = mode1type_q;
    assign hold.hold_runcmd = runcmd_q;
    assign hold.holding_mode1 = holding_mode1_q;
    assign hold.holding_fwu = holding_fwu_q;
    assign hold.holding_runcmd = holding_runcmd_q;
    // live pulse counts too, so pps in the capture cycle is not lost
    assign hold.pps_local = tfio_pps_i || pps_seen_q;

    assign mode1_tready_o = mode1_ack_q;
    assign fw_tready_o = fw_ack_q;
    assign runcmd_tready_o = runcmd_ack_q;
    assign trig_tready_o = trig_ack_q;

endmodule

//--- cmd_splice.sv
`timescale 1ns/1ns

module cmd_splice (
    input  rackbus_pkg::rackbus_word_u            command_i,
    input  logic                                  command_locked_i,
    input  logic                                  use_tfio_pps_i,
    input  logic                                  trig_tvalid_i,
    input  logic [rackbus_pkg::TRIG_BITS-1:0]     trig_tdata_i,
    output rackbus_pkg::rackbus_word_u            spliced_o,
    splice_hold_if.splice                         hold
);
    import rackbus_pkg::*;

    logic                      turf_mode1_invalid;
    logic                      turf_runcmd_invalid;
    logic                      turf_trig_valid;
    logic                      turf_pps;
    logic                      pps;
    logic                      tfio_has_data;
    logic                      total_ignore;
    logic [MODE1_BITS-1:0]     mode1data;
    logic [MODE1TYPE_BITS-1:0] mode1type;
    logic [RUNCMD_BITS-1:0]    runcmd;
    logic [TRIG_BITS-1:0]      trig;
    logic                      trig_valid;

    // upstream mode1 field is empty when unlocked, ignored,
    // or when it holds the special/noop pair
    assign turf_mode1_invalid = !command_locked_i || command_i.f.ignore ||
                                ((command_i.f.mode1type == MODE1_SPECIAL) &&
                                 (command_i.f.mode1data == MODE1_NOOP));

    // same idea for the run command
    assign turf_runcmd_invalid = !command_locked_i || command_i.f.ignore ||
                                 (command_i.f.runcmd == RUNCMD_NOOP);

    // trigger bits stand alone, only the lock matters
    assign turf_trig_valid = command_locked_i && command_i.f.trig_valid;

    // holding registers always hold something sendable, noop at worst
    assign mode1data = turf_mode1_invalid ? hold.hold_mode1data : command_i.f.mode1data;
    assign mode1type = turf_mode1_invalid ? hold.hold_mode1type : command_i.f.mode1type;
    assign runcmd = turf_runcmd_invalid ? hold.hold_runcmd : command_i.f.runcmd;

    // local trigger is taken live
    assign trig = turf_trig_valid ? command_i.f.trig : trig_tdata_i;
    assign trig_valid = turf_trig_valid || trig_tvalid_i;

    // pps source select
    assign turf_pps = command_i.f.pps && command_locked_i && !command_i.f.ignore;
    assign pps = use_tfio_pps_i ? hold.pps_local : turf_pps;

    // any local data for the upper fields clears ignore
    assign tfio_has_data = hold.holding_mode1 || hold.holding_fwu || hold.holding_runcmd ||
                           (hold.pps_local && use_tfio_pps_i);

    // locked upstream with all zeros keeps ignore clear
    // nothing happens then anyway, fields are all noop
    assign total_ignore = (command_i.f.ignore || !command_locked_i) && !tfio_has_data;

    // assemble the spliced word by field
    always_comb begin
        spliced_o = '0;
        spliced_o.f.ignore = total_ignore;
        spliced_o.f.pps = pps;
        spliced_o.f.runcmd = runcmd;
        spliced_o.f.mode1type = mode1type;
        spliced_o.f.mode1data = mode1data;
        spliced_o.f.trig_valid = trig_valid;
        spliced_o.f.trig = trig;
    end

    // status back to the holding side for its ready pulses
    assign hold.turf_mode1_invalid = turf_mode1_invalid;
    assign hold.turf_runcmd_invalid = turf_runcmd_invalid;
    assign hold.turf_trig_valid = turf_trig_valid;

endmodule

//--- cmd_serializer.sv
`timescale 1ns/1ns

module cmd_serializer #(
    parameter int SER_BITS = 4
) (
    input  logic                       sysclk_i,
    input  logic                       rst_i,
    input  logic                       capture_i,
    input  rackbus_pkg::rackbus_word_u word_i,
    output logic [31:0]                cmd_word_o,
    output logic                       cmd_word_valid_o,
    output logic                       frame_o,
    output logic [SER_BITS-1:0]        rack_cmd_o
);
    import rackbus_pkg::*;

    // lanes per word, at most one frame long
    localparam int LANES = WORD_BITS / SER_BITS;
    localparam int CNT_BITS = 4;

    logic [WORD_BITS-1:0] word_q;
    logic [WORD_BITS-1:0] shift_q;
    logic [CNT_BITS-1:0]  lane_cnt_q;
    logic                 valid_q;
    logic                 frame_q;

    // control: valid and frame pulse right after capture
    // lane_cnt_q counts the shifts still to do
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            frame_q <= 1'b0;
            lane_cnt_q <= '0;
        end else begin
            valid_q <= capture_i;
            frame_q <= capture_i;
            if (capture_i) begin
                lane_cnt_q <= CNT_BITS'(LANES - 1);
            end else if (lane_cnt_q != '0) begin
                lane_cnt_q <= lane_cnt_q - 1'b1;
            end
        end
    end

    // word register and shifter, msb lane leaves first
    always_ff @(posedge sysclk_i) begin
        if (capture_i) begin
            word_q <= word_i.raw;
            shift_q <= word_i.raw;
        end else if (lane_cnt_q != '0) begin
            shift_q <= shift_q << SER_BITS;
        end
    end

    assign cmd_word_o = word_q;
    assign cmd_word_valid_o = valid_q;
    assign frame_o = frame_q;
    assign rack_cmd_o = shift_q[WORD_BITS-1 -: SER_BITS];

endmodule

//--- rack_cmd_top.sv
`timescale 1ns/1ns

module rack_cmd_top #(
    parameter int SER_BITS = 4
) (
    input  logic                                   sysclk_i,
    input  logic                                   rst_i,
    input  logic                                   sync_i,
    // upstream controller
    input  logic [31:0]                            command_i,
    input  logic                                   command_locked_i,
    input  logic                                   use_tfio_pps_i,
    // local mode1 stream
    input  logic                                   mode1_tvalid_i,
    input  logic [rackbus_pkg::MODE1_BITS-1:0]     mode1_tdata_i,
    input  logic [rackbus_pkg::MODE1TYPE_BITS-1:0] mode1_tuser_i,
    output logic                                   mode1_tready_o,
    // local firmware update bytes
    input  logic                                   fw_tvalid_i,
    input  logic [rackbus_pkg::MODE1_BITS-1:0]     fw_tdata_i,
    output logic                                   fw_tready_o,
    // local run commands
    input  logic                                   runcmd_tvalid_i,
    input  logic [rackbus_pkg::RUNCMD_BITS-1:0]    runcmd_tdata_i,
    output logic                                   runcmd_tready_o,
    // local triggers
    input  logic                                   trig_tvalid_i,
    input  logic [rackbus_pkg::TRIG_BITS-1:0]      trig_tdata_i,
    output logic                                   trig_tready_o,
    input  logic                                   tfio_pps_i,
    // spliced word out
    output logic [31:0]                            cmd_word_o,
    output logic                                   cmd_word_valid_o,
    output logic                                   frame_o,
    output logic [SER_BITS-1:0]                    rack_cmd_o
);
    import rackbus_pkg::*;

    logic          precapture;
    logic          capture;
    rackbus_word_u command_w;
    rackbus_word_u spliced_w;

    splice_hold_if hold_if ();

    assign command_w.raw = command_i;

    cmd_phase_gen u_phase (
        .sysclk_i     (sysclk_i),
        .rst_i        (rst_i),
        .sync_i       (sync_i),
        .precapture_o (precapture),
        .capture_o    (capture)
    );

    tfio_holding u_holding (
        .sysclk_i        (sysclk_i),
        .rst_i           (rst_i),
        .precapture_i    (precapture),
        .capture_i       (capture),
        .mode1_tvalid_i  (mode1_tvalid_i),
        .mode1_tdata_i   (mode1_tdata_i),
        .mode1_tuser_i   (mode1_tuser_i),
        .fw_tvalid_i     (fw_tvalid_i),
        .fw_tdata_i      (fw_tdata_i),
        .runcmd_tvalid_i (runcmd_tvalid_i),
        .runcmd_tdata_i  (runcmd_tdata_i),
        .trig_tvalid_i   (trig_tvalid_i),
        .tfio_pps_i      (tfio_pps_i),
        .mode1_tready_o  (mode1_tready_o),
        .fw_tready_o     (fw_tready_o),
        .runcmd_tready_o (runcmd_tready_o),
        .trig_tready_o   (trig_tready_o),
        .hold            (hold_if)
    );

    cmd_splice u_splice (
        .command_i        (command_w),
        .command_locked_i (command_locked_i),
        .use_tfio_pps_i   (use_tfio_pps_i),
        .trig_tvalid_i    (trig_tvalid_i),
        .trig_tdata_i     (trig_tdata_i),
        .spliced_o        (spliced_w),
        .hold             (hold_if)
    );

    cmd_serializer #(
        .SER_BITS (SER_BITS)
    ) u_ser (
        .sysclk_i         (sysclk_i),
        .rst_i            (rst_i),
        .capture_i        (capture),
        .word_i           (spliced_w),
        .cmd_word_o       (cmd_word_o),
        .cmd_word_valid_o (cmd_word_valid_o),
        .frame_o          (frame_o),
        .rack_cmd_o       (rack_cmd_o)
    );

endmodule

//--- tb_rack_cmd_top.sv
`timescale 1ns/1ns

module tb_rack_cmd_top;
    import rackbus_pkg::*;

    localparam int SER_BITS = 4;
    localparam int NUM_FRAMES = 24;
    localparam int CLK_PERIOD = 4;

    logic                      sysclk_i;
    logic                      rst_i;
    logic                      sync_i;
    logic [31:0]               command_i;
    logic                      command_locked_i;
    logic                      use_tfio_pps_i;
    logic                      mode1_tvalid_i;
    logic [MODE1_BITS-1:0]     mode1_tdata_i;
    logic [MODE1TYPE_BITS-1:0] mode1_tuser_i;
    logic                      mode1_tready_o;
    logic                      fw_tvalid_i;
    logic [MODE1_BITS-1:0]     fw_tdata_i;
    logic                      fw_tready_o;
    logic                      runcmd_tvalid_i;
    logic [RUNCMD_BITS-1:0]    runcmd_tdata_i;
    logic                      runcmd_tready_o;
    logic                      trig_tvalid_i;
    logic [TRIG_BITS-1:0]      trig_tdata_i;
    logic                      trig_tready_o;
    logic                      tfio_pps_i;
    logic [31:0]               cmd_word_o;
    logic                      cmd_word_valid_o;
    logic                      frame_o;
    logic [SER_BITS-1:0]       rack_cmd_o;

    // expected values for the word that is in flight
    rackbus_word_u exp_word;
    logic exp_mode1_rdy;
    logic exp_fw_rdy;
    logic exp_runcmd_rdy;
    logic exp_trig_rdy;
    // prediction for the frame just driven that is promoted one cycle later
    rackbus_word_u next_word;
    logic next_mode1_rdy;
    logic next_fw_rdy;
    logic next_runcmd_rdy;
    logic next_trig_rdy;

    logic [31:0] rng_state;
    int          error_count;

    // serial lane collector
    logic [31:0] ser_acc;
    logic [2:0]  ser_cnt;

    rack_cmd_top #(
        .SER_BITS (SER_BITS)
    ) uut (
        .sysclk_i         (sysclk_i),
        .rst_i            (rst_i),
        .sync_i           (sync_i),
        .command_i        (command_i),
        .command_locked_i (command_locked_i),
        .use_tfio_pps_i   (use_tfio_pps_i),
        .mode1_tvalid_i   (mode1_tvalid_i),
        .mode1_tdata_i    (mode1_tdata_i),
        .mode1_tuser_i    (mode1_tuser_i),
        .mode1_tready_o   (mode1_tready_o),
        .fw_tvalid_i      (fw_tvalid_i),
        .fw_tdata_i       (fw_tdata_i),
        .fw_tready_o      (fw_tready_o),
        .runcmd_tvalid_i  (runcmd_tvalid_i),
        .runcmd_tdata_i   (runcmd_tdata_i),
        .runcmd_tready_o  (runcmd_tready_o),
        .trig_tvalid_i    (trig_tvalid_i),
        .trig_tdata_i     (trig_tdata_i),
        .trig_tready_o    (trig_tready_o),
        .tfio_pps_i       (tfio_pps_i),
        .cmd_word_o       (cmd_word_o),
        .cmd_word_valid_o (cmd_word_valid_o),
        .frame_o          (frame_o),
        .rack_cmd_o       (rack_cmd_o)
    );

    initial begin
        sysclk_i = 1'b0;
        forever #(CLK_PERIOD / 2) sysclk_i = ~sysclk_i;
    end

    // word and ready pulses against the model
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        cmd_word_valid_o |-> (cmd_word_o == exp_word.raw))
    else begin
        error_count++;
        $display("mismatch at %0t: word %h, expected %h", $time, cmd_word_o, exp_word.raw);
    end

    assert property (@(posedge sysclk_i) disable iff (rst_i)
        cmd_word_valid_o |-> (mode1_tready_o == exp_mode1_rdy) && (fw_tready_o == exp_fw_rdy))
    else begin
        error_count++;
        $display("mismatch at %0t: mode1/fw ready %b%b, expected %b%b", $time,
                 mode1_tready_o, fw_tready_o, exp_mode1_rdy, exp_fw_rdy);
    end

    assert property (@(posedge sysclk_i) disable iff (rst_i)
        cmd_word_valid_o |-> (runcmd_tready_o == exp_runcmd_rdy) &&
                             (trig_tready_o == exp_trig_rdy))
    else begin
        error_count++;
        $display("mismatch at %0t: runcmd/trig ready %b%b, expected %b%b", $time,
                 runcmd_tready_o, trig_tready_o, exp_runcmd_rdy, exp_trig_rdy);
    end

    // ready pulses only ever ride along with the word
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        !cmd_word_valid_o |-> !(mode1_tready_o || fw_tready_o ||
                                runcmd_tready_o || trig_tready_o))
    else begin
        error_count++;
        $display("mismatch at %0t: ready pulse outside a word", $time);
    end

    // frame marker comes with the first lane in the word valid cycle
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        frame_o == cmd_word_valid_o)
    else begin
        error_count++;
        $display("mismatch at %0t: frame %b, word valid %b", $time,
                 frame_o, cmd_word_valid_o);
    end

    // lanes arrive msb first starting with frame_o
    // count wraps back to zero after the last lane
    always @(posedge sysclk_i) begin
        if (rst_i) begin
            ser_cnt <= '0;
        end else if (frame_o) begin
            ser_acc <= {28'b0, rack_cmd_o};
            ser_cnt <= 3'd1;
        end else if (ser_cnt != 3'd0) begin
            ser_acc <= {ser_acc[27:0], rack_cmd_o};
            ser_cnt <= ser_cnt + 3'd1;
        end
    end

    // last lane is live in cycle 7 while the word register still holds
    assert property (@(posedge sysclk_i) disable iff (rst_i)
        (ser_cnt == 3'd7) |-> ({ser_acc[27:0], rack_cmd_o} == cmd_word_o))
    else begin
        error_count++;
        $display("mismatch at %0t: serial word %h, word %h", $time,
                 {ser_acc[27:0], rack_cmd_o}, cmd_word_o);
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // upstream word with chosen control fields and random payload
    function automatic logic [31:0] make_cmd(input logic ign, input logic [1:0] rc,
                                             input logic [1:0] mt, input logic [7:0] md,
                                             input logic tv);
        rackbus_word_u w;
        w.raw = next_rand();
        w.f.ignore = ign;
        w.f.runcmd = rc;
        w.f.mode1type = mt;
        w.f.mode1data = md;
        w.f.trig_valid = tv;
        return w.raw;
    endfunction

    // splice rules applied to the inputs now driven
    task automatic predict_frame(input logic pps_pulse);
        rackbus_word_u up;
        rackbus_word_u w;
        logic mode1_empty;
        logic runcmd_empty;
        logic up_trig;
        logic use_fw;
        logic has_local;
        up.raw = command_i;
        mode1_empty = !command_locked_i || up.f.ignore ||
                      (up.f.mode1type == MODE1_SPECIAL && up.f.mode1data == MODE1_NOOP);
        runcmd_empty = !command_locked_i || up.f.ignore || (up.f.runcmd == RUNCMD_NOOP);
        up_trig = command_locked_i && up.f.trig_valid;
        use_fw = fw_tvalid_i && !mode1_tvalid_i;
        w.raw = '0;
        w.f.mode1type = up.f.mode1type;
        w.f.mode1data = up.f.mode1data;
        if (mode1_empty) begin
            w.f.mode1type = mode1_tvalid_i ? mode1_tuser_i : (use_fw ? MODE1_FWU : MODE1_SPECIAL);
            w.f.mode1data = mode1_tvalid_i ? mode1_tdata_i : (use_fw ? fw_tdata_i : MODE1_NOOP);
        end
        w.f.runcmd = up.f.runcmd;
        if (runcmd_empty) begin
            w.f.runcmd = runcmd_tvalid_i ? runcmd_tdata_i : RUNCMD_NOOP;
        end
        w.f.trig_valid = up_trig || trig_tvalid_i;
        w.f.trig = up_trig ? up.f.trig : trig_tdata_i;
        w.f.pps = use_tfio_pps_i ? pps_pulse : (up.f.pps && command_locked_i && !up.f.ignore);
        has_local = mode1_tvalid_i || fw_tvalid_i || runcmd_tvalid_i ||
                    (pps_pulse && use_tfio_pps_i);
        w.f.ignore = (up.f.ignore || !command_locked_i) && !has_local;
        next_word = w;
        next_mode1_rdy = mode1_tvalid_i && mode1_empty;
        next_fw_rdy = use_fw && mode1_empty;
        next_runcmd_rdy = runcmd_tvalid_i && runcmd_empty;
        next_trig_rdy = trig_tvalid_i && !up_trig;
    endtask

    // drive one frame in phase 0 and then wait for its word
    task automatic run_frame(input logic [31:0] cmd, input logic locked, input logic use_pps,
                             input logic m1v, input logic fwv, input logic rcv,
                             input logic tv, input logic pps_pulse);
        command_i = cmd;
        command_locked_i = locked;
        use_tfio_pps_i = use_pps;
        mode1_tvalid_i = m1v;
        mode1_tdata_i = next_rand();
        mode1_tuser_i = next_rand();
        fw_tvalid_i = fwv;
        fw_tdata_i = next_rand();
        runcmd_tvalid_i = rcv;
        runcmd_tdata_i = next_rand();
        trig_tvalid_i = tv;
        trig_tdata_i = next_rand();
        predict_frame(pps_pulse);
        // previous word is checked on the coming edge
        @(negedge sysclk_i);
        exp_word = next_word;
        exp_mode1_rdy = next_mode1_rdy;
        exp_fw_rdy = next_fw_rdy;
        exp_runcmd_rdy = next_runcmd_rdy;
        exp_trig_rdy = next_trig_rdy;
        repeat (2) @(negedge sysclk_i);
        // mid-frame pps pulse
        tfio_pps_i = pps_pulse;
        @(negedge sysclk_i);
        tfio_pps_i = 1'b0;
        @(negedge sysclk_i);
        while (!cmd_word_valid_o) begin
            @(negedge sysclk_i);
        end
    endtask

    initial begin
        rng_state = 32'ha071;
        error_count = 0;
        rst_i = 1'b1;
        sync_i = 1'b0;
        command_i = '0;
        command_locked_i = 1'b0;
        use_tfio_pps_i = 1'b0;
        mode1_tvalid_i = 1'b0;
        mode1_tdata_i = '0;
        mode1_tuser_i = '0;
        fw_tvalid_i = 1'b0;
        fw_tdata_i = '0;
        runcmd_tvalid_i = 1'b0;
        runcmd_tdata_i = '0;
        trig_tvalid_i = 1'b0;
        trig_tdata_i = '0;
        tfio_pps_i = 1'b0;
        exp_word.raw = '0;
        {exp_mode1_rdy, exp_fw_rdy, exp_runcmd_rdy, exp_trig_rdy} = '0;
        repeat (5) @(negedge sysclk_i);
        rst_i = 1'b0;
        sync_i = 1'b1;
        @(negedge sysclk_i);
        sync_i = 1'b0;

        // full upstream words pass and local sources all wait
        repeat (3) begin
            run_frame(make_cmd(1'b0, 2'd1 + next_rand() % 3, next_rand() % 3, next_rand(), 1'b1),
                      1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
        end
        // unlocked with and without local data
        run_frame(next_rand(), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        run_frame(next_rand(), 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
        // mode1 beats firmware beats noop
        run_frame(make_cmd(1'b0, 2'd2, MODE1_SPECIAL, MODE1_NOOP, 1'b1),
                  1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        run_frame(make_cmd(1'b0, 2'd2, MODE1_SPECIAL, MODE1_NOOP, 1'b1),
                  1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_frame(make_cmd(1'b0, 2'd2, MODE1_SPECIAL, MODE1_NOOP, 1'b1),
                  1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        // run command only into an empty upstream slot
        run_frame(make_cmd(1'b0, RUNCMD_NOOP, 2'd1, next_rand(), 1'b1),
                  1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        run_frame(make_cmd(1'b0, 2'd3, 2'd1, next_rand(), 1'b1),
                  1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        // local trigger, then local and upstream pps
        run_frame(make_cmd(1'b0, 2'd1, 2'd0, next_rand(), 1'b0),
                  1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        run_frame(make_cmd(1'b0, 2'd1, 2'd0, next_rand(), 1'b0),
                  1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        run_frame(make_cmd(1'b0, 2'd1, 2'd0, next_rand(), 1'b0) | 32'h4000_0000,
                  1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        // random mix
        repeat (NUM_FRAMES - 13) begin
            run_frame(next_rand(), next_rand() % 4 != 0, next_rand() % 2, next_rand() % 2,
                      next_rand() % 2, next_rand() % 2, next_rand() % 2, next_rand() % 2);
        end
        repeat (2) @(negedge sysclk_i);

        $display("checks done, errors: %0d", error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog sized from the frame count
    initial begin
        #((NUM_FRAMES + 10) * 8 * CLK_PERIOD);
        $display("timeout: the run did not finish its frames in time");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- sources.f
rackbus_pkg.sv
splice_hold_if.sv
cmd_phase_gen.sv
tfio_holding.sv
cmd_splice.sv
cmd_serializer.sv
rack_cmd_top.sv
tb_rack_cmd_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_rack_cmd_top -o sim_tb \
    && ./obj_dir/sim_tb | tee sim.log \
    && grep -qx "=== PASS ===" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
